/* design/simd_alu_pkg.sv */
package simd_alu_pkg;

    // **************************************************
    // datapath sizes
    // **************************************************
    localparam int DATA_W     = 64;
    localparam int BYTE_W     = 8;
    localparam int NUM_BYTES  = DATA_W / BYTE_W;   // byte slices in a word
    localparam int NUM_WIDTHS = 4;                 // b, h, w, d

    typedef logic [DATA_W-1:0] word_t;     // operand / result, lane 0 at the top
    typedef logic [5:0]        alu_op_t;
    typedef logic [1:0]        width_sel_t;
    typedef logic [1:0]        unit_sel_t;
    typedef logic [1:0]        variant_t;

    // **************************************************
    // opcodes, same numbering as the cpu isa
    // **************************************************
    localparam alu_op_t OP_AND   = 6'd1;
    localparam alu_op_t OP_OR    = 6'd2;
    localparam alu_op_t OP_XOR   = 6'd3;
    localparam alu_op_t OP_NOT   = 6'd4;
    localparam alu_op_t OP_ADD   = 6'd6;
    localparam alu_op_t OP_SUB   = 6'd7;
    localparam alu_op_t OP_MULEU = 6'd8;
    localparam alu_op_t OP_MULOU = 6'd9;
    localparam alu_op_t OP_SLL   = 6'd10;
    localparam alu_op_t OP_SRL   = 6'd11;
    localparam alu_op_t OP_RTTH  = 6'd13;
    localparam alu_op_t OP_SQEU  = 6'd16;
    localparam alu_op_t OP_SQOU  = 6'd17;
    localparam alu_op_t OP_NOP   = 6'd23;

    // lane width codes
    localparam width_sel_t WIDTH_B = 2'd0;   // 8 bit lanes
    localparam width_sel_t WIDTH_H = 2'd1;   // 16
    localparam width_sel_t WIDTH_W = 2'd2;   // 32
    localparam width_sel_t WIDTH_D = 2'd3;   // one 64 bit lane

    // producing unit
    localparam unit_sel_t UNIT_LOGIC  = 2'd0;
    localparam unit_sel_t UNIT_ADDSUB = 2'd1;
    localparam unit_sel_t UNIT_SHIFT  = 2'd2;
    localparam unit_sel_t UNIT_MUL    = 2'd3;

    // sub-ops, meaning depends on unit
    localparam variant_t VAR_AND   = 2'd0;
    localparam variant_t VAR_OR    = 2'd1;
    localparam variant_t VAR_XOR   = 2'd2;
    localparam variant_t VAR_NOT   = 2'd3;
    localparam variant_t VAR_ADD   = 2'd0;
    localparam variant_t VAR_SUB   = 2'd1;   // bit 0 marks subtract
    localparam variant_t VAR_SLL   = 2'd0;
    localparam variant_t VAR_SRL   = 2'd1;
    localparam variant_t VAR_RTTH  = 2'd2;
    localparam variant_t VAR_MULEU = 2'd0;   // bit 0 odd lanes, bit 1 square
    localparam variant_t VAR_MULOU = 2'd1;
    localparam variant_t VAR_SQEU  = 2'd2;
    localparam variant_t VAR_SQOU  = 2'd3;

endpackage

/* design/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode import simd_alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_valid,
    input  alu_op_t    alu_op,
    input  width_sel_t width,
    input  word_t      reg_a_data,
    input  word_t      reg_b_data,
    output logic       s1_valid,
    output unit_sel_t  s1_unit,
    output variant_t   s1_variant,
    output width_sel_t s1_width,
    output logic       s1_error,
    output word_t      s1_a,
    output word_t      s1_b
);

    unit_sel_t  dec_unit;
    variant_t   dec_variant;
    width_sel_t dec_width;
    logic       dec_error;

    // **************************************************
    // opcode -> unit / variant
    // **************************************************
    always_comb begin
        dec_unit    = UNIT_LOGIC;
        dec_variant = VAR_AND;
        dec_width   = width;
        dec_error   = 1'b0;
        case (alu_op)
            OP_AND: dec_variant = VAR_AND;
            OP_OR:  dec_variant = VAR_OR;
            OP_XOR: dec_variant = VAR_XOR;
            OP_NOT: dec_variant = VAR_NOT;
            OP_ADD: begin
                dec_unit    = UNIT_ADDSUB;
                dec_variant = VAR_ADD;
            end
            OP_SUB: begin
                dec_unit    = UNIT_ADDSUB;
                dec_variant = VAR_SUB;
            end
            OP_SLL, OP_SRL, OP_RTTH: begin
                dec_unit    = UNIT_SHIFT;
                dec_variant = (alu_op == OP_SLL) ? VAR_SLL :
                              (alu_op == OP_SRL) ? VAR_SRL : VAR_RTTH;
            end
            OP_MULEU: begin
                dec_unit    = UNIT_MUL;
                dec_variant = VAR_MULEU;
            end
            OP_MULOU: begin
                dec_unit    = UNIT_MUL;
                dec_variant = VAR_MULOU;
            end
            OP_SQEU: begin
                dec_unit    = UNIT_MUL;
                dec_variant = VAR_SQEU;
            end
            OP_SQOU: begin
                dec_unit    = UNIT_MUL;
                dec_variant = VAR_SQOU;
            end
            OP_NOP: begin
                // multiplier at double width gives zero, no error raised
                dec_unit  = UNIT_MUL;
                dec_width = WIDTH_D;
            end
            default: dec_error = 1'b1;   // dropped or unknown opcode
        endcase
        // no widening product fits a 64 bit lane
        if (dec_unit == UNIT_MUL && width == WIDTH_D && alu_op != OP_NOP)
            dec_error = 1'b1;
    end

    // stage 1 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_error <= 1'b0;
        end else begin
            s1_valid <= op_valid;
            if (op_valid)
                s1_error <= dec_error;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (op_valid) begin
            s1_unit    <= dec_unit;
            s1_variant <= dec_variant;
            s1_width   <= dec_width;
            s1_a       <= reg_a_data;
            s1_b       <= reg_b_data;
        end
    end

endmodule

/* design/lane_addsub.sv */
`timescale 1ns/1ps

module lane_addsub import simd_alu_pkg::*; (
    input  word_t      s1_a,
    input  word_t      s1_b,
    input  width_sel_t s1_width,
    input  variant_t   s1_variant,
    output word_t      sum_result
);

    logic                 sub;         // subtract when set
    word_t                b_eff;       // b, inverted for subtract
    logic [2:0]           lane_mask;   // low byte-index bits inside a lane
    logic [NUM_BYTES-2:0] carry;       // carry out of each byte slice but the top

    assign sub   = s1_variant[0];
    assign b_eff = sub ? ~s1_b : s1_b;   // a + ~b + 1 per lane

    // byte index bits that stay inside one lane
    always_comb begin
        case (s1_width)
            WIDTH_B: lane_mask = 3'b000;
            WIDTH_H: lane_mask = 3'b001;
            WIDTH_W: lane_mask = 3'b011;
            WIDTH_D: lane_mask = 3'b111;
            default: lane_mask = 3'b000;
        endcase
    end

    // **************************************************
    // byte slices, chain cut at lane boundaries
    // **************************************************
    for (genvar j = 0; j < NUM_BYTES; j++) begin : g_byte
        localparam logic [2:0] IDX = 3'(j);   // byte 0 is the lsb byte
        logic cin;

        if (j == 0) begin : g_first
            assign cin = sub;   // always a lane start
        end else begin : g_rest
            // a byte whose index bits are clear under the mask opens a lane
            assign cin = ((IDX & lane_mask) == 3'b000) ? sub : carry[j-1];
        end

        if (j == NUM_BYTES - 1) begin : g_top
            // carry out of the word is dropped
            assign sum_result[BYTE_W*j +: BYTE_W] =
                s1_a[BYTE_W*j +: BYTE_W] + b_eff[BYTE_W*j +: BYTE_W] + BYTE_W'(cin);
        end else begin : g_mid
            assign {carry[j], sum_result[BYTE_W*j +: BYTE_W]} =
                {1'b0, s1_a[BYTE_W*j +: BYTE_W]} + {1'b0, b_eff[BYTE_W*j +: BYTE_W]}
                + (BYTE_W+1)'(cin);
        end
    end

endmodule

/* design/lane_shifter.sv */
`timescale 1ns/1ps

module lane_shifter import simd_alu_pkg::*; (
    input  word_t      s1_a,
    input  word_t      s1_b,
    input  width_sel_t s1_width,
    input  variant_t   s1_variant,
    output word_t      shift_result
);

    // one full result per lane width, picked at the end
    word_t width_res [NUM_WIDTHS];

    // **************************************************
    // per width, per lane shift / rotate
    // **************************************************
    for (genvar w = 0; w < NUM_WIDTHS; w++) begin : g_width
        localparam int LW    = BYTE_W << w;     // lane width in bits
        localparam int SW    = 3 + w;           // shift amount bits, log2 of LW
        localparam int LANES = DATA_W / LW;

        for (genvar l = 0; l < LANES; l++) begin : g_lane
            logic [LW-1:0] a_lane;
            logic [SW-1:0] amt;       // low bits of the matching b lane
            logic [LW-1:0] res;

            assign a_lane = s1_a[l*LW +: LW];
            assign amt    = s1_b[l*LW +: SW];

            always_comb begin
                case (s1_variant)
                    VAR_SLL:  res = a_lane << amt;   // zeros in from the right
                    VAR_SRL:  res = a_lane >> amt;   // zeros in from the left
                    VAR_RTTH: res = {a_lane[LW/2-1:0], a_lane[LW-1:LW/2]};   // swap halves
                    default:  res = '0;
                endcase
            end

            assign width_res[w][l*LW +: LW] = res;
        end
    end

    // lane width select
    assign shift_result = width_res[s1_width];

endmodule

/* design/lane_multiplier.sv */
`timescale 1ns/1ps

module lane_multiplier import simd_alu_pkg::*; (
    input  word_t      s1_a,
    input  word_t      s1_b,
    input  width_sel_t s1_width,
    input  variant_t   s1_variant,
    output word_t      mul_result
);

    logic  odd;      // variant bit 0
    logic  square;   // variant bit 1, b replaced by a
    word_t prod [NUM_WIDTHS-1];   // b, h, w only

    assign odd    = s1_variant[0];
    assign square = s1_variant[1];

    // **************************************************
    // widening products, one per double-width slot
    // **************************************************
    // a slot of 2*LW bits holds one even lane (top half) and the
    // following odd lane (bottom half), so the product of either one
    // lands back in the slot it came from
    for (genvar w = 0; w < NUM_WIDTHS - 1; w++) begin : g_width
        localparam int LW    = BYTE_W << w;
        localparam int SLOTS = DATA_W / (2 * LW);

        for (genvar s = 0; s < SLOTS; s++) begin : g_slot
            logic [LW-1:0]   op_a;
            logic [LW-1:0]   op_b;
            logic [LW-1:0]   b_sel;

            // even lane sits in the upper half of the slot
            assign op_a  = odd ? s1_a[s*2*LW +: LW] : s1_a[s*2*LW + LW +: LW];
            assign b_sel = odd ? s1_b[s*2*LW +: LW] : s1_b[s*2*LW + LW +: LW];
            assign op_b  = square ? op_a : b_sel;

            // zero extend, unsigned lanes
            assign prod[w][s*2*LW +: 2*LW] = {{LW{1'b0}}, op_a} * {{LW{1'b0}}, op_b};
        end
    end

    always_comb begin
        case (s1_width)
            WIDTH_B: mul_result = prod[0];
            WIDTH_H: mul_result = prod[1];
            WIDTH_W: mul_result = prod[2];
            WIDTH_D: mul_result = '0;   // no room for a 128 bit product
            default: mul_result = '0;
        endcase
    end

endmodule

/* design/alu_writeback.sv */
`timescale 1ns/1ps

module alu_writeback import simd_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      s1_valid,
    input  unit_sel_t s1_unit,
    input  variant_t  s1_variant,
    input  logic      s1_error,
    input  word_t     s1_a,
    input  word_t     s1_b,
    input  word_t     sum_result,
    input  word_t     shift_result,
    input  word_t     mul_result,
    output logic      result_valid,
    output word_t     alu_out,
    output logic      op_error
);

    word_t logic_res;   // bitwise unit, width independent
    word_t next_out;

    // **************************************************
    // bitwise ops
    // **************************************************
    always_comb begin
        case (s1_variant)
            VAR_AND: logic_res = s1_a & s1_b;
            VAR_OR:  logic_res = s1_a | s1_b;
            VAR_XOR: logic_res = s1_a ^ s1_b;
            VAR_NOT: logic_res = ~s1_a;   // b ignored
            default: logic_res = '0;
        endcase
    end

    // result mux
    always_comb begin
        case (s1_unit)
            UNIT_LOGIC:  next_out = logic_res;
            UNIT_ADDSUB: next_out = sum_result;
            UNIT_SHIFT:  next_out = shift_result;
            UNIT_MUL:    next_out = mul_result;
            default:     next_out = '0;
        endcase
        if (s1_error)
            next_out = '0;   // bad op reads back as zero
    end

    // **************************************************
    // stage 2 register
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            op_error     <= 1'b0;
        end else begin
            result_valid <= s1_valid;              // one pulse per op
            op_error     <= s1_valid & s1_error;
        end
    end

    // holds between results
    always_ff @(posedge clk) begin
        if (s1_valid)
            alu_out <= next_out;
    end

endmodule

/* design/simd_alu.sv */
`timescale 1ns/1ps

module simd_alu import simd_alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_valid,
    input  alu_op_t    alu_op,
    input  width_sel_t width,
    input  word_t      reg_a_data,
    input  word_t      reg_b_data,
    output logic       result_valid,
    output word_t      alu_out,
    output logic       op_error
);

    // stage 1 state
    logic       s1_valid;
    unit_sel_t  s1_unit;
    variant_t   s1_variant;
    width_sel_t s1_width;
    logic       s1_error;
    word_t      s1_a;
    word_t      s1_b;

    // unit results, combinational off stage 1
    word_t sum_result;
    word_t shift_result;
    word_t mul_result;

    // **************************************************
    // stage 1 decode
    // **************************************************
    alu_decode alu_decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .alu_op     (alu_op),
        .width      (width),
        .reg_a_data (reg_a_data),
        .reg_b_data (reg_b_data),
        .s1_valid   (s1_valid),
        .s1_unit    (s1_unit),
        .s1_variant (s1_variant),
        .s1_width   (s1_width),
        .s1_error   (s1_error),
        .s1_a       (s1_a),
        .s1_b       (s1_b)
    );

    // parallel lane units
    lane_addsub lane_addsub_inst (
        .s1_a       (s1_a),
        .s1_b       (s1_b),
        .s1_width   (s1_width),
        .s1_variant (s1_variant),
        .sum_result (sum_result)
    );

    lane_shifter lane_shifter_inst (
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .s1_width     (s1_width),
        .s1_variant   (s1_variant),
        .shift_result (shift_result)
    );

    lane_multiplier lane_multiplier_inst (
        .s1_a       (s1_a),
        .s1_b       (s1_b),
        .s1_width   (s1_width),
        .s1_variant (s1_variant),
        .mul_result (mul_result)
    );

    // **************************************************
    // stage 2 select and register
    // **************************************************
    alu_writeback alu_writeback_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .s1_unit      (s1_unit),
        .s1_variant   (s1_variant),
        .s1_error     (s1_error),
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .sum_result   (sum_result),
        .shift_result (shift_result),
        .mul_result   (mul_result),
        .result_valid (result_valid),
        .alu_out      (alu_out),
        .op_error     (op_error)
    );

endmodule

/* verif/simd_alu_properties.sv */
`timescale 1ns/1ps

module simd_alu_properties import simd_alu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       op_valid,
    input alu_op_t    alu_op,
    input width_sel_t width,
    input logic       s1_valid,
    input logic       result_valid,
    input logic       op_error,
    input word_t      alu_out
);

    logic err_now;   // error the inputs of this cycle should raise
    logic nop_now;

    // error rule from the isa, per opcode and width
    function automatic logic bad_op(alu_op_t op, width_sel_t w);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_ADD, OP_SUB,
            OP_SLL, OP_SRL, OP_RTTH, OP_NOP:
                return 1'b0;
            OP_MULEU, OP_MULOU, OP_SQEU, OP_SQOU:
                return w == WIDTH_D;   // product would not fit
            default:
                return 1'b1;
        endcase
    endfunction

    assign err_now = bad_op(alu_op, width);
    assign nop_now = (alu_op == OP_NOP);

    // **************************************************
    // pipeline timing and result checks
    // **************************************************
    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(op_valid, 2))
        else $error("result_valid is not op_valid delayed by two cycles");

    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> op_error == $past(err_now, 2))
        else $error("op_error does not match the op issued two cycles earlier");

    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && op_error |-> alu_out == '0)
        else $error("failed op returned a nonzero result");

    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && $past(nop_now, 2) |-> alu_out == '0 && !op_error)
        else $error("nop did not return a clean zero");

    // flags cleared one edge into reset
    assert property (@(posedge clk)
        $past(rst_n) == 1'b0 |-> !result_valid && !op_error && !s1_valid)
        else $error("pipeline flags not cleared by reset");

endmodule

bind simd_alu simd_alu_properties simd_alu_props_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .alu_op       (alu_op),
    .width        (width),
    .s1_valid     (s1_valid),
    .result_valid (result_valid),
    .op_error     (op_error),
    .alu_out      (alu_out)
);

/* verif/simd_alu_tb.sv */
`timescale 1ns/1ps

module simd_alu_tb import simd_alu_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 10;
    localparam int TOTAL_OPS  = 32 + 16 + 32 + 24 + 200;   // all five tests
    localparam alu_op_t MUL_OPS [4] = '{OP_MULEU, OP_MULOU, OP_SQEU, OP_SQOU};
    localparam alu_op_t SHIFT_OPS [3] = '{OP_SLL, OP_SRL, OP_RTTH};

    logic       clk = 1'b0;
    logic       rst_n;
    logic       op_valid;
    alu_op_t    alu_op;
    width_sel_t width;
    word_t      reg_a_data;
    word_t      reg_b_data;
    logic       result_valid;
    word_t      alu_out;
    logic       op_error;

    integer seed = 9208;
    int     checks = 0;
    int     errors = 0;
    int     base_checks = 0;   // counts at the start of the current test
    int     base_errors = 0;
    word_t  exp_out [$];       // scoreboard, oldest op first
    logic   exp_err [$];
    word_t  want_out;
    logic   want_err;

    always #(CLK_PERIOD / 2) clk = ~clk;

    simd_alu simd_alu_inst (.*);

    // **************************************************
    // reference model, lane 0 at the top
    // **************************************************
    function automatic word_t trunc(word_t v, int lw);
        return v & ((lw == 64) ? '1 : (64'd1 << lw) - 1);
    endfunction

    function automatic word_t lane(word_t v, int lw, int t);
        return trunc(v >> (64 - (t + 1) * lw), lw);
    endfunction

    function automatic word_t model(alu_op_t op, width_sel_t w, word_t a, word_t b,
                                    output logic err);
        int    lw;
        int    odd;
        word_t r;
        word_t x;
        word_t y;
        lw  = 8 << w;
        odd = (op == OP_MULOU || op == OP_SQOU) ? 1 : 0;
        r   = '0;
        err = 1'b0;
        case (op)
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_NOT: r = ~a;
            OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_RTTH:
                for (int t = 0; t < 64 / lw; t++) begin
                    x = lane(a, lw, t);
                    y = lane(b, lw, t);
                    case (op)
                        OP_ADD:  x = x + y;             // carry dropped by trunc
                        OP_SUB:  x = x - y;
                        OP_SLL:  x = x << (y % lw);     // low bits of b lane only
                        OP_SRL:  x = x >> (y % lw);
                        default: x = (x << (lw / 2)) | (x >> (lw / 2));
                    endcase
                    r = r | (trunc(x, lw) << (64 - (t + 1) * lw));
                end
            OP_MULEU, OP_MULOU, OP_SQEU, OP_SQOU: begin
                err = (w == WIDTH_D);
                for (int k = 0; k < 32 / lw; k++) begin   // double-width slots
                    x = lane(a, lw, 2 * k + odd);
                    y = (op == OP_SQEU || op == OP_SQOU) ? x : lane(b, lw, 2 * k + odd);
                    r = r | ((x * y) << (64 - (k + 1) * 2 * lw));
                end
            end
            OP_NOP:  r = '0;
            default: err = 1'b1;
        endcase
        return err ? '0 : r;
    endfunction

    function automatic word_t rnd();
        return {$random(seed), $random(seed)};
    endfunction

    // one op per call, inputs change 1 ns after the edge
    task automatic issue(alu_op_t op, width_sel_t w, word_t a, word_t b);
        logic  err;
        word_t r;
        r          = model(op, w, a, b, err);
        op_valid   = 1'b1;
        alu_op     = op;
        width      = w;
        reg_a_data = a;
        reg_b_data = b;
        exp_out.push_back(r);
        exp_err.push_back(err);
        @(posedge clk);
        #1;
    endtask

    // drain the pipe, then report the test
    task automatic end_test(string name);
        op_valid = 1'b0;
        do
            @(posedge clk);
        while (exp_out.size() != 0);
        #1;
        $display("%s: %0d checks, %0d errors", name, checks - base_checks,
                 errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    // **************************************************
    // result checker, sampled mid cycle
    // **************************************************
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_out.size() == 0) begin
                $display("result_valid seen at %0t with no op in flight", $time);
                errors++;
            end else begin
                want_out = exp_out.pop_front();
                want_err = exp_err.pop_front();
                checks++;
                assert (alu_out === want_out && op_error === want_err)
                    else begin
                        $display("FAIL %0t: alu_out %h op_error %b, expected %h %b",
                                 $time, alu_out, op_error, want_out, want_err);
                        errors++;
                    end
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        alu_op     = OP_NOP;
        width      = WIDTH_B;
        reg_a_data = '0;
        reg_b_data = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int w = 0; w < 4; w++)                   // and, or, xor, not
            for (int v = 0; v < 8; v++)
                issue(OP_AND + 6'(v % 4), width_sel_t'(w), rnd(), rnd());
        end_test("bitwise");

        for (int w = 0; w < 4; w++) begin             // every lane wraps
            issue(OP_ADD, width_sel_t'(w), '1, 64'h0101_0101_0101_0101);
            issue(OP_ADD, width_sel_t'(w), 64'h8080_8080_8080_8080, 64'h8080_8080_8080_8080);
            issue(OP_SUB, width_sel_t'(w), '0, 64'h0101_0101_0101_0101);
            issue(OP_SUB, width_sel_t'(w), rnd(), rnd());
        end
        end_test("add_sub");

        for (int w = 0; w < 4; w++)                   // double width must error
            for (int v = 0; v < 8; v++)
                issue(MUL_OPS[v % 4], width_sel_t'(w), rnd(), rnd());
        end_test("multiply");

        for (int w = 0; w < 4; w++)                   // random then max amount
            for (int v = 0; v < 6; v++)
                issue(SHIFT_OPS[v % 3], width_sel_t'(w), rnd(), (v < 3) ? rnd() : '1);
        end_test("shift");

        // back to back, unknown opcodes and nop mixed in
        repeat (200)
            issue(alu_op_t'({$random(seed)} % 24), width_sel_t'($random(seed)), rnd(), rnd());
        end_test("random");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog, sized from the op count plus drain margin
    initial begin
        #((RST_CYCLES + TOTAL_OPS + 60) * CLK_PERIOD);
        $display("watchdog expired before all results came back");
        $display("test failed");
        $finish;
    end

endmodule

/* simd_alu.f */
design/simd_alu_pkg.sv
design/alu_decode.sv
design/lane_addsub.sv
design/lane_shifter.sv
design/lane_multiplier.sv
design/alu_writeback.sv
design/simd_alu.sv
verif/simd_alu_properties.sv
verif/simd_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the simd_alu testbench with verilator, run it, then check the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module simd_alu_tb \
    -f simd_alu.f -o simd_alu_sim &&
./obj_dir/simd_alu_sim | tee sim.log &&
grep -q "^test passed$" sim.log &&
echo "run_sim: simulation ok" ||
{ echo "run_sim: simulation did not pass"; exit 1; }
